//--- design/filter_defines.svh
/* Filter bench parameters
   Sample widths, pulse shape, pulse rates and filter lengths */
`ifndef FILTER_DEFINES_SVH
`define FILTER_DEFINES_SVH

// --------------------
// Data widths
// --------------------
`define SIZE_ADC_DATA    14
`define SIZE_FILTER_DATA 24
`define SIZE_DELAY       8

// Each clock a pulse loses its value >> TAU_SHIFT
`define PULSE_AMPLITUDE  8000
`define TAU_SHIFT        4
`define PERIOD_SLOW      256
`define PERIOD_FAST      128

// Filter lengths in samples
`define MA_LOG2          3
`define TRAP_RISE        8
`define TRAP_FLAT        4
`endif

//--- design/filter_pkg.sv
/* Filter bench package
   Sample types and FSM state encodings */
`default_nettype none
`include "filter_defines.svh"

package filter_pkg;

	// --------------------
	// Sample types
	// --------------------
	// Raw generator code is unsigned
	typedef logic [`SIZE_ADC_DATA-1:0] adc_data_t;
	// Filter results are signed
	typedef logic signed [`SIZE_FILTER_DATA-1:0] filter_data_t;

	// --------------------
	// FSM states
	// --------------------
	// Pulse channel
	typedef enum logic {SHAPER_IDLE, SHAPER_DECAY} shaper_state_t;
	// Overlay scheduler
	typedef enum logic {SCHED_WAIT_MAIN, SCHED_WAIT_OVERLAY} sched_state_t;

endpackage
`default_nettype wire

//--- design/exp_pulse_shaper.sv
/* Exponential pulse channel
   Loads the amplitude on fire, then decays by a shifted copy of itself */
`default_nettype none
`include "filter_defines.svh"

module exp_pulse_shaper (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  fire,
	output filter_pkg::adc_data_t sample
);
	import filter_pkg::*;

	shaper_state_t state;
	adc_data_t     value;
	// Amount lost this clock
	adc_data_t     decrement;

	assign decrement = value >> `TAU_SHIFT;
	assign sample    = value;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= SHAPER_IDLE;
			value <= '0;
		end else if (fire) begin
			// Fire wins, also restarts a pulse in flight
			state <= SHAPER_DECAY;
			value <= adc_data_t'(`PULSE_AMPLITUDE);
		end else begin
			case (state)
				SHAPER_IDLE: begin
					// Hold value, residue stays on the output
					state <= SHAPER_IDLE;
				end
				SHAPER_DECAY: begin
					// Tail ends once the shift runs out of bits
					if (decrement == '0)
						state <= SHAPER_IDLE;
					else
						value <= value - decrement;
				end
				default: state <= SHAPER_IDLE;
			endcase
		end
	end

endmodule
`default_nettype wire

//--- design/exp_sig_gen.sv
/* Pulse train generator
   Period scheduler, optional delayed overlay pulse and saturating sum */
`default_nettype none
`include "filter_defines.svh"

module exp_sig_gen (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    overlay,
	input  logic                    rate,
	input  logic [`SIZE_DELAY-1:0]  delay,
	output filter_pkg::adc_data_t   output_data
);
	import filter_pkg::*;

	localparam int PERIOD_MAX = (`PERIOD_SLOW > `PERIOD_FAST) ? `PERIOD_SLOW : `PERIOD_FAST;
	localparam int CNT_W = $clog2(PERIOD_MAX);
	localparam logic [CNT_W-1:0] TERM_SLOW = CNT_W'(`PERIOD_SLOW - 1);
	localparam logic [CNT_W-1:0] TERM_FAST = CNT_W'(`PERIOD_FAST - 1);

	logic [CNT_W-1:0]       period_cnt;
	// Terminal count of the running period
	logic [CNT_W-1:0]       period_term;
	logic                   main_fire;
	logic                   overlay_fire;
	logic                   overlay_ok;
	sched_state_t           sched_state;
	logic [`SIZE_DELAY-1:0] delay_cnt;
	adc_data_t              main_sample;
	adc_data_t              overlay_sample;
	// One extra bit for the carry
	logic [`SIZE_ADC_DATA:0] sum;

	// --------------------
	// Period counter
	// --------------------
	assign main_fire = (period_cnt == period_term);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			period_cnt  <= '0;
			period_term <= TERM_SLOW;
		end else begin
			if (main_fire)
				period_cnt <= '0;
			else
				period_cnt <= period_cnt + 1'b1;
			// Rate taken on the first count after a wrap
			if (period_cnt == '0)
				period_term <= rate ? TERM_FAST : TERM_SLOW;
		end
	end

	// --------------------
	// Overlay scheduler
	// --------------------
	// Delay must be nonzero and inside the period
	assign overlay_ok   = overlay && (delay != '0) && (32'(delay) <= 32'(period_term));
	assign overlay_fire = (sched_state == SCHED_WAIT_OVERLAY) && (delay_cnt == '0);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sched_state <= SCHED_WAIT_MAIN;
			delay_cnt   <= '0;
		end else if (main_fire) begin
			// Every main pulse restarts the wait
			sched_state <= overlay_ok ? SCHED_WAIT_OVERLAY : SCHED_WAIT_MAIN;
			delay_cnt   <= delay - 1'b1;
		end else if (sched_state == SCHED_WAIT_OVERLAY) begin
			if (delay_cnt == '0)
				sched_state <= SCHED_WAIT_MAIN;
			else
				delay_cnt <= delay_cnt - 1'b1;
		end
	end

	// Two channels
	exp_pulse_shaper u_main_shaper (
		.clk    (clk),
		.rst_n  (rst_n),
		.fire   (main_fire),
		.sample (main_sample)
	);

	exp_pulse_shaper u_overlay_shaper (
		.clk    (clk),
		.rst_n  (rst_n),
		.fire   (overlay_fire),
		.sample (overlay_sample)
	);

	// Sum clipped at full scale
	assign sum = {1'b0, main_sample} + {1'b0, overlay_sample};

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			output_data <= '0;
		else
			output_data <= sum[`SIZE_ADC_DATA] ? '1 : sum[`SIZE_ADC_DATA-1:0];
	end

endmodule
`default_nettype wire

//--- design/moving_avg_filter.sv
/* Boxcar moving average
   Running sum over a power-of-two window, scaled down by the window length */
`default_nettype none
`include "filter_defines.svh"

module moving_avg_filter (
	input  logic                     clk,
	input  logic                     rst_n,
	input  filter_pkg::adc_data_t    input_data,
	output filter_pkg::filter_data_t output_data
);
	import filter_pkg::*;

	localparam int DEPTH = 1 << `MA_LOG2;
	// Room for DEPTH full scale samples
	localparam int SUM_W = `SIZE_ADC_DATA + `MA_LOG2;

	// Window contents with [0] as the newest past sample
	adc_data_t        window [DEPTH];
	logic [SUM_W-1:0] sum_q;
	logic [SUM_W-1:0] sum_next;

	// --------------------
	// Running sum
	// --------------------
	// New sample in, sample DEPTH back out
	assign sum_next = sum_q + SUM_W'(input_data) - SUM_W'(window[DEPTH-1]);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < DEPTH; i++)
				window[i] <= '0;
			sum_q <= '0;
		end else begin
			window[0] <= input_data;
			for (int i = 1; i < DEPTH; i++)
				window[i] <= window[i-1];
			sum_q <= sum_next;
		end
	end

	// --------------------
	// Output stage
	// --------------------
	// Mean of the window ending at this input
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			output_data <= '0;
		else
			output_data <= filter_data_t'(sum_next >> `MA_LOG2);
	end

endmodule
`default_nettype wire

//--- design/trapezoid_filter.sv
/* Trapezoidal shaper
   Four tap difference, pole-zero correction against the decay, double accumulation */
`default_nettype none
`include "filter_defines.svh"

module trapezoid_filter (
	input  logic                     clk,
	input  logic                     rst_n,
	input  filter_pkg::adc_data_t    input_data,
	output filter_pkg::filter_data_t output_data
);
	import filter_pkg::*;

	// Tap offsets in samples
	localparam int TAP_RISE  = `TRAP_RISE;
	localparam int TAP_FLAT  = `TRAP_RISE + `TRAP_FLAT;
	localparam int TAP_FALL  = 2 * `TRAP_RISE + `TRAP_FLAT;
	localparam int DEPTH     = TAP_FALL;

	// [k] holds the sample k+1 clocks back
	adc_data_t    taps [DEPTH];
	filter_data_t diff_next;
	filter_data_t diff_q;
	// First accumulator
	filter_data_t p_q;

	// --------------------
	// Delay line
	// --------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < DEPTH; i++)
				taps[i] <= '0;
		end else begin
			taps[0] <= input_data;
			for (int i = 1; i < DEPTH; i++)
				taps[i] <= taps[i-1];
		end
	end

	// Signs plus, minus, minus, plus
	assign diff_next = filter_data_t'(input_data)
	                 - filter_data_t'(taps[TAP_RISE-1])
	                 - filter_data_t'(taps[TAP_FLAT-1])
	                 + filter_data_t'(taps[TAP_FALL-1]);

	// --------------------
	// Stage one
	// --------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			diff_q <= '0;
		else
			diff_q <= diff_next;
	end

	// --------------------
	// Stage two
	// --------------------
	// Old p plus diff times 2^TAU undoes the generator decay of 1 - 2^-TAU
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			p_q         <= '0;
			output_data <= '0;
		end else begin
			p_q         <= p_q + diff_q;
			// Flat top near amplitude * rise * 2^TAU
			output_data <= output_data + p_q + (diff_q <<< `TAU_SHIFT);
		end
	end

endmodule
`default_nettype wire

//--- design/filter.sv
/* Filter bench top level
   Pulse generator feeding a moving average and a trapezoidal shaper */
`default_nettype none
`include "filter_defines.svh"

module filter (
	input  logic                     clk,
	input  logic                     rst_n,
	// Static test controls
	input  logic                     test_overlay,
	input  logic                     test_rate,
	input  logic [`SIZE_DELAY-1:0]   test_delay,
	// Raw samples and filter results
	output filter_pkg::adc_data_t    output_data,
	output filter_pkg::filter_data_t output_ma,
	output filter_pkg::filter_data_t output_trap
);

	// --------------------
	// Generator
	// --------------------
	exp_sig_gen u_exp_sig_gen (
		.clk         (clk),
		.rst_n       (rst_n),
		.overlay     (test_overlay),
		.rate        (test_rate),
		.delay       (test_delay),
		.output_data (output_data)
	);

	// --------------------
	// Filters
	// --------------------
	// Both run on the same raw stream
	moving_avg_filter u_filter_ma (
		.clk         (clk),
		.rst_n       (rst_n),
		.input_data  (output_data),
		.output_data (output_ma)
	);

	trapezoid_filter u_filter_trap (
		.clk         (clk),
		.rst_n       (rst_n),
		.input_data  (output_data),
		.output_data (output_trap)
	);

endmodule
`default_nettype wire

//--- sim/tb_filter.sv
/* Filter bench testbench
   File-driven tests against cycle models of the generator and both filters */
`default_nettype none
`include "filter_defines.svh"

module tb_filter;
	timeunit 1ns;
	timeprecision 1ps;
	import filter_pkg::*;

	localparam int MAX_TESTS = 32;
	localparam int RESET_CYCLES = 10;
	localparam int ADC_MAX = (1 << `SIZE_ADC_DATA) - 1;
	localparam int HIST = 2 * `TRAP_RISE + `TRAP_FLAT;

	logic                   clk;
	logic                   rst_n;
	logic                   test_overlay;
	logic                   test_rate;
	logic [`SIZE_DELAY-1:0] test_delay;
	adc_data_t              output_data;
	filter_data_t           output_ma;
	filter_data_t           output_trap;

	// Test table from the data file
	int t_ov[MAX_TESTS], t_rate[MAX_TESTS], t_delay[MAX_TESTS];
	int t_len[MAX_TESTS], t_peak[MAX_TESTS], t_flat[MAX_TESTS];
	int    n_tests;
	int    total_len;
	bit    loaded;
	int    errors;
	int    pass_count;
	int    fail_count;
	int    seed = 32'hcbedc6f1;

	// Reference model state
	int m_cnt, m_term, m_sched, m_dcnt, m_raw, m_ma, m_trap, m_p, m_diff;
	int m_val[2];
	bit m_st[2];
	int hist[HIST];

	filter u_filter (
		.clk          (clk),
		.rst_n        (rst_n),
		.test_overlay (test_overlay),
		.test_rate    (test_rate),
		.test_delay   (test_delay),
		.output_data  (output_data),
		.output_ma    (output_ma),
		.output_trap  (output_trap)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Compare with tolerance, report on mismatch
	task automatic check(input string what, input int got, input int exp, input int tol);
		if (got > exp + tol || got < exp - tol) begin
			errors++;
			$display("[ERROR] %0t: %s got %0d expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic load_tests(output bit ok);
		int    fd;
		string line;
		int    a, b, c, d, e, f;
		fd = $fopen("sim/testdata_filter.txt", "r");
		ok = (fd != 0);
		n_tests = 0;
		total_len = 0;
		while (ok && !$feof(fd) && n_tests < MAX_TESTS) begin
			line = "";
			void'($fgets(line, fd));
			// Skip comments and blanks
			if (line.len() > 1 && line[0] != 8'h23 &&
			    $sscanf(line, "%d %d %d %d %d %d", a, b, c, d, e, f) == 6) begin
				t_ov[n_tests] = a;
				t_rate[n_tests] = b;
				t_delay[n_tests] = c;
				t_len[n_tests] = d;
				t_peak[n_tests] = e;
				t_flat[n_tests] = f;
				total_len += d;
				n_tests++;
			end
		end
		if (fd != 0)
			$fclose(fd);
	endtask

	task automatic model_reset();
		m_cnt = 0;
		m_term = `PERIOD_SLOW - 1;
		m_sched = 0;
		m_dcnt = 0;
		m_raw = 0;
		m_ma = 0;
		m_trap = 0;
		m_p = 0;
		m_diff = 0;
		m_val = '{0, 0};
		m_st = '{0, 0};
		foreach (hist[k]) hist[k] = 0;
	endtask

	// One clock of the generator, moving average and trapezoid rules
	task automatic model_step(input int ov, input int rate, input int dly);
		int mf, of, ok, sum, x, ma_sum, dn, dec;
		bit fire[2];
		mf = (m_cnt == m_term);
		of = m_sched && (m_dcnt == 0);
		ok = ov && (dly != 0) && (dly < m_term + 1);
		x = m_raw;
		sum = m_val[0] + m_val[1];
		ma_sum = x;
		for (int k = 0; k < (1 << `MA_LOG2) - 1; k++)
			ma_sum += hist[k];
		m_ma = ma_sum >> `MA_LOG2;
		dn = x - hist[`TRAP_RISE-1] - hist[`TRAP_RISE+`TRAP_FLAT-1] + hist[HIST-1];
		m_trap = m_trap + m_p + m_diff * (1 << `TAU_SHIFT);
		m_p += m_diff;
		m_diff = dn;
		for (int k = HIST - 1; k > 0; k--)
			hist[k] = hist[k-1];
		hist[0] = x;
		m_raw = (sum > ADC_MAX) ? ADC_MAX : sum;
		fire[0] = mf;
		fire[1] = of;
		for (int c = 0; c < 2; c++) begin
			dec = m_val[c] >> `TAU_SHIFT;
			if (fire[c]) begin
				m_st[c] = 1;
				m_val[c] = `PULSE_AMPLITUDE;
			end else if (m_st[c]) begin
				if (dec == 0) m_st[c] = 0;
				else m_val[c] -= dec;
			end
		end
		if (mf) begin
			m_sched = ok;
			m_dcnt = dly - 1;
		end else if (m_sched) begin
			if (m_dcnt == 0) m_sched = 0;
			else m_dcnt--;
		end
		if (m_cnt == 0)
			m_term = rate ? `PERIOD_FAST - 1 : `PERIOD_SLOW - 1;
		m_cnt = mf ? 0 : m_cnt + 1;
	endtask

	task automatic run_test(input int t);
		int err0, first_nz, peak, trap_max, period, rnd;
		err0 = errors;
		first_nz = -1;
		peak = 0;
		trap_max = 0;
		period = t_rate[t] ? `PERIOD_FAST : `PERIOD_SLOW;
		// Controls set while reset is held
		rst_n = 1'b0;
		test_overlay = t_ov[t][0];
		test_rate = t_rate[t][0];
		test_delay = t_delay[t][`SIZE_DELAY-1:0];
		model_reset();
		repeat (RESET_CYCLES) @(posedge clk);
		#5 rst_n = 1'b1;
		check("output_data in reset", int'(output_data), 0, 0);
		check("output_ma in reset", int'(output_ma), 0, 0);
		check("output_trap in reset", int'(output_trap), 0, 0);
		for (int n = 1; n <= t_len[t]; n++) begin
			@(posedge clk);
			#5;
			model_step(test_overlay, test_rate, test_delay);
			check("output_data", int'(output_data), m_raw, 0);
			check("output_ma", int'(output_ma), m_ma, 0);
			check("output_trap", int'(output_trap), m_trap, 0);
			if (first_nz < 0 && output_data != '0) first_nz = n;
			if (int'(output_data) > peak) peak = int'(output_data);
			if (int'(output_trap) > trap_max) trap_max = int'(output_trap);
			// Last test walks through random delays
			if (t == n_tests - 1 && n % period == 0) begin
				rnd = $random(seed);
				test_delay = rnd[`SIZE_DELAY-1:0];
			end
		end
		// Shaper load plus output register after the first fire
		check("first pulse clock", first_nz, period + 1, 0);
		if (t_peak[t] != 0) check("output_data peak", peak, t_peak[t], 0);
		if (t_flat[t] != 0) check("output_trap flat top", trap_max, t_flat[t], t_flat[t] / 50);
		if (errors == err0) pass_count++;
		else fail_count++;
		$display("test %0d overlay=%0d rate=%0d delay=%0d: %s", t, t_ov[t], t_rate[t],
		         t_delay[t], (errors == err0) ? "pass" : "fail");
	endtask

	// --------------------
	// Watchdog
	// --------------------
	initial begin
		longint limit;
		wait (loaded);
		limit = longint'(total_len + (RESET_CYCLES + 2) * n_tests) * 3 / 2 * 100;
		#(limit);
		$display("Watchdog expired before all tests finished");
		$display("Test FAILED");
		$finish;
	end

	initial begin
		bit ok;
		rst_n = 1'b0;
		test_overlay = 1'b0;
		test_rate = 1'b0;
		test_delay = '0;
		errors = 0;
		pass_count = 0;
		fail_count = 0;
		load_tests(ok);
		if (!ok || n_tests == 0) begin
			$display("Could not read any tests from sim/testdata_filter.txt");
			$display("Test FAILED");
			$finish;
		end else begin
			loaded = 1'b1;
			for (int t = 0; t < n_tests; t++)
				run_test(t);
			$display("%0d tests passed, %0d failed", pass_count, fail_count);
			if (fail_count == 0 && errors == 0)
				$display("Test OK");
			else
				$display("Test FAILED");
			$finish;
		end
	end

endmodule
`default_nettype wire

//--- sim/testdata_filter.txt
# overlay rate delay run_clocks expected_peak expected_trap_flat_top
# peak or flat top of 0 is not checked; the last line uses random delays
# Isolated pulses, slow rate
0 0 0 1024 8000 1024000
# Isolated pulses, fast rate
0 1 0 512 8000 1024000
# Overlay one clock after the main pulse
1 0 1 768 15500 0
# Overlay two clocks later
1 1 2 512 15032 0
# Overlay three clocks later
1 1 3 512 14593 0
# Overlay four clocks later, slow rate
1 0 4 768 14181 0
# Delay 0 gives no overlay
1 1 0 512 8000 1024000
# Delay equal to the fast period gives no overlay
1 1 128 512 8000 1024000
# Delay inside the slow period but not the fast one
1 1 200 512 8000 1024000
# Random overlay delays
1 1 5 1536 0 0

//--- compile.f
+incdir+design
design/filter_pkg.sv
design/exp_pulse_shaper.sv
design/exp_sig_gen.sv
design/moving_avg_filter.sv
design/trapezoid_filter.sv
design/filter.sv
sim/tb_filter.sv

//--- Makefile
# Verilator build and run of the filter bench testbench

VERILATOR ?= verilator
TOP       ?= tb_filter
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= compile.f
VFLAGS    ?= --binary --timing -Wno-fatal

BIN  := $(OBJ_DIR)/V$(TOP)
SRCS := $(wildcard design/*.sv design/*.svh sim/*.sv)

.PHONY: all build run clean

all: run

build: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: $(BIN) sim/testdata_filter.txt
	./$(BIN) 2>&1 | tee $(LOG)
	@grep -q "^Test OK$$" $(LOG) || (echo "Simulation failed" && exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
